// ==== bp_pkg.sv ====
package bp_pkg;

	// --------------------
	// Widths.
	// --------------------
	localparam int IP_W        = 64;  // Instruction address.
	localparam int KEY_ENTRY_W = 16;  // Upper bound on the bank entry index.
	localparam int MISS_CNT_W  = 32;
	localparam int CNT_W       = 2;   // Saturating counter.

	// Top bit of the encoding is the predicted direction.
	typedef enum logic [CNT_W-1:0] {
		STRONG_NT = 2'd0,
		WEAK_NT   = 2'd1,
		WEAK_T    = 2'd2,
		STRONG_T  = 2'd3
	} bp_counter_t;

	// --------------------
	// Structs.
	// --------------------
	typedef struct packed {
		logic [KEY_ENTRY_W-1:0] entry;  // Entry within the bank.
		logic [IP_W-1:0]        tag;    // Address shifted right by the index width.
	} bp_key_t;

	typedef struct packed {
		bp_key_t key;
		logic    taken;  // Resolved outcome.
	} bp_update_t;

	typedef struct packed {
		logic        hit;
		logic        prediction;
		bp_counter_t counter;
	} bp_result_t;

endpackage

// ==== bp_addr_decode.sv ====
`timescale 1ns/1ps

module bp_addr_decode #(
	parameter int NUM_BANKS  = 4,
	parameter int BANK_DEPTH = 64
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [bp_pkg::IP_W-1:0]      ip,
	input  logic                         taken,
	output bp_pkg::bp_key_t              lookup_key,
	output logic [$clog2(NUM_BANKS)-1:0] lookup_bank,
	output bp_pkg::bp_update_t           update,
	output logic [NUM_BANKS-1:0]         update_en
);

	localparam int BANK_W  = $clog2(NUM_BANKS);
	localparam int ENTRY_W = $clog2(BANK_DEPTH);
	localparam int INDEX_W = BANK_W + ENTRY_W;

	logic [bp_pkg::IP_W-1:0] prev_ip;     // Address looked up last cycle.
	logic                    prev_valid;

	// Bank in the low bits, entry above it, tag in the rest.
	function automatic bp_pkg::bp_key_t make_key(input logic [bp_pkg::IP_W-1:0] addr);
		bp_pkg::bp_key_t key;
		key = '0;
		key.entry[ENTRY_W-1:0] = addr[BANK_W +: ENTRY_W];
		key.tag = addr >> INDEX_W;
		return key;
	endfunction

	assign lookup_key  = make_key(ip);
	assign lookup_bank = ip[BANK_W-1:0];

	always_ff @(posedge clk) begin
		prev_ip <= ip;
		if (!rst_n) begin
			prev_valid <= 1'b0;
		end else begin
			prev_valid <= 1'b1;
		end
	end

	// Outcome this cycle belongs to last cycle's address.
	assign update.key   = make_key(prev_ip);
	assign update.taken = taken;

	always_comb begin
		update_en = '0;
		if (prev_valid) begin
			update_en[prev_ip[BANK_W-1:0]] = 1'b1;
		end
	end

	a_update_en_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(update_en) && (!$past(rst_n) -> update_en == '0));

endmodule

// ==== bp_bank.sv ====
`timescale 1ns/1ps

module bp_bank #(
	parameter int BANK_DEPTH = 64,
	parameter int TAG_W      = 56
) (
	input  logic               clk,
	input  logic               rst_n,
	input  bp_pkg::bp_key_t    lookup_key,
	input  bp_pkg::bp_update_t update,
	input  logic               update_en,
	output bp_pkg::bp_result_t result
);

	localparam int ENTRY_W = $clog2(BANK_DEPTH);

	logic [TAG_W-1:0]    tag_mem [BANK_DEPTH];
	bp_pkg::bp_counter_t cnt_mem [BANK_DEPTH];

	logic [ENTRY_W-1:0]  lk_entry;
	logic                lk_hit;
	bp_pkg::bp_counter_t lk_cnt;

	logic [ENTRY_W-1:0]  up_entry;
	logic [TAG_W-1:0]    up_tag;
	logic                up_hit;
	bp_pkg::bp_counter_t up_cnt;
	bp_pkg::bp_counter_t up_cnt_next;

	// --------------------
	// Lookup.
	// --------------------
	assign lk_entry = lookup_key.entry[ENTRY_W-1:0];
	assign lk_cnt   = cnt_mem[lk_entry];
	assign lk_hit   = (tag_mem[lk_entry] == lookup_key.tag[TAG_W-1:0]);

	assign result.hit        = lk_hit;
	assign result.counter    = lk_cnt;
	assign result.prediction = lk_hit & lk_cnt[bp_pkg::CNT_W-1];  // Miss predicts not taken.

	// --------------------
	// Update.
	// --------------------
	assign up_entry = update.key.entry[ENTRY_W-1:0];
	assign up_tag   = update.key.tag[TAG_W-1:0];
	assign up_cnt   = cnt_mem[up_entry];
	assign up_hit   = (tag_mem[up_entry] == up_tag);

	// One step toward the outcome, held at both ends.
	always_comb begin
		up_cnt_next = up_cnt;
		if (update.taken && up_cnt != bp_pkg::STRONG_T) begin
			up_cnt_next = bp_pkg::bp_counter_t'(up_cnt + 2'd1);
		end else if (!update.taken && up_cnt != bp_pkg::STRONG_NT) begin
			up_cnt_next = bp_pkg::bp_counter_t'(up_cnt - 2'd1);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < BANK_DEPTH; i++) begin
				tag_mem[i] <= '0;
				cnt_mem[i] <= bp_pkg::WEAK_T;
			end
		end else if (update_en) begin
			if (up_hit) begin
				cnt_mem[up_entry] <= up_cnt_next;
			end else begin
				// Reallocate with a weak counter in the outcome's direction.
				tag_mem[up_entry] <= up_tag;
				cnt_mem[up_entry] <= update.taken ? bp_pkg::WEAK_T : bp_pkg::WEAK_NT;
			end
		end
	end

	a_update_entry_range: assert property (@(posedge clk) disable iff (!rst_n)
		update_en |-> (update.key.entry < BANK_DEPTH));

endmodule

// ==== bp_result_select.sv ====
`timescale 1ns/1ps

module bp_result_select #(
	parameter int NUM_BANKS = 4
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  bp_pkg::bp_result_t              bank_results [NUM_BANKS],
	input  logic [$clog2(NUM_BANKS)-1:0]    lookup_bank,
	input  logic                            taken,
	output logic                            hit,
	output logic                            prediction,
	output logic [bp_pkg::MISS_CNT_W-1:0]   miss_count
);

	bp_pkg::bp_result_t sel;
	logic               prev_pred;   // Prediction given last cycle.
	logic               prev_valid;

	assign sel        = bank_results[lookup_bank];
	assign hit        = sel.hit;
	assign prediction = sel.prediction;

	always_ff @(posedge clk) begin
		prev_pred <= sel.prediction;
		if (!rst_n) begin
			prev_valid <= 1'b0;
			miss_count <= '0;
		end else begin
			prev_valid <= 1'b1;
			if (prev_valid && prev_pred != taken) begin
				miss_count <= miss_count + 1'b1;  // Outcome disagreed.
			end
		end
	end

	// --------------------
	// Checks.
	// --------------------
	a_miss_count_mono: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> miss_count >= $past(miss_count));

endmodule

// ==== branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor #(
	parameter int NUM_BANKS  = 4,   // Power of two.
	parameter int BANK_DEPTH = 64   // Power of two.
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [bp_pkg::IP_W-1:0]       ip,
	input  logic                          taken,
	output logic                          hit,
	output logic                          prediction,
	output logic [bp_pkg::MISS_CNT_W-1:0] miss_count
);

	localparam int BANK_W  = $clog2(NUM_BANKS);
	localparam int INDEX_W = BANK_W + $clog2(BANK_DEPTH);
	localparam int TAG_W   = bp_pkg::IP_W - INDEX_W;  // 56 with the defaults.

	bp_pkg::bp_key_t    lookup_key;
	logic [BANK_W-1:0]  lookup_bank;
	bp_pkg::bp_update_t update;
	logic [NUM_BANKS-1:0] update_en;
	bp_pkg::bp_result_t bank_results [NUM_BANKS];

	bp_addr_decode #(
		.NUM_BANKS  (NUM_BANKS),
		.BANK_DEPTH (BANK_DEPTH)
	) i_addr_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.ip          (ip),
		.taken       (taken),
		.lookup_key  (lookup_key),
		.lookup_bank (lookup_bank),
		.update      (update),
		.update_en   (update_en)
	);

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		bp_bank #(
			.BANK_DEPTH (BANK_DEPTH),
			.TAG_W      (TAG_W)
		) i_bank (
			.clk        (clk),
			.rst_n      (rst_n),
			.lookup_key (lookup_key),
			.update     (update),
			.update_en  (update_en[b]),
			.result     (bank_results[b])
		);
	end

	bp_result_select #(
		.NUM_BANKS (NUM_BANKS)
	) i_result_select (
		.clk          (clk),
		.rst_n        (rst_n),
		.bank_results (bank_results),
		.lookup_bank  (lookup_bank),
		.taken        (taken),
		.hit          (hit),
		.prediction   (prediction),
		.miss_count   (miss_count)
	);

endmodule

// ==== bp_checker.sv ====
`timescale 1ns/1ps

module bp_checker (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [8*24-1:0]               test_name,  // Text of the running test.
	input  logic [bp_pkg::IP_W-1:0]       ip,
	input  logic                          taken,
	input  logic                          hit,
	input  logic                          prediction,
	input  logic [bp_pkg::MISS_CNT_W-1:0] miss_count,
	input  logic                          exp_hit,
	input  logic                          exp_pred,
	output int                            hit_errors,
	output int                            pred_errors,
	output int                            miss_errors
);

	logic [bp_pkg::MISS_CNT_W-1:0] exp_miss;    // Expected miss count.
	logic                          prev_pred;   // Expected prediction of last cycle.
	logic                          prev_valid;

	initial begin
		hit_errors  = 0;
		pred_errors = 0;
		miss_errors = 0;
		exp_miss    = '0;
		prev_pred   = 1'b0;
		prev_valid  = 1'b0;
	end

	// --------------------
	// Compare at the rising edge, before the DUT registers move.
	// --------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			exp_miss   = '0;
			prev_valid = 1'b0;
		end else begin
			if (hit !== exp_hit) begin
				hit_errors++;
				$display("** Error %0s: hit for ip %h expected %0b, actual %0b",
					test_name, ip, exp_hit, hit);
			end
			if (prediction !== exp_pred) begin
				pred_errors++;
				$display("** Error %0s: prediction for ip %h expected %0b, actual %0b",
					test_name, ip, exp_pred, prediction);
			end
			if (miss_count !== exp_miss) begin
				miss_errors++;
				$display("** Error %0s: miss_count expected %0d, actual %0d",
					test_name, exp_miss, miss_count);
			end
			// Outcome now on taken resolves last cycle's prediction.
			if (prev_valid && prev_pred != taken) begin
				exp_miss = exp_miss + 1;
			end
			prev_pred  = exp_pred;
			prev_valid = 1'b1;
		end
	end

endmodule

// ==== tb_branch_predictor.sv ====
`timescale 1ns/1ps

module tb_branch_predictor;

	localparam int RESET_CYCLES   = 10;
	localparam int DIRECTED_LEN   = 35;
	localparam int RAND_LEN       = 2000;
	localparam int FLUSH_LEN      = 2;
	localparam int STIM_CYCLES    = 2 * RESET_CYCLES + DIRECTED_LEN + RAND_LEN + FLUSH_LEN;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;
	localparam int TAG_BITS       = bp_pkg::IP_W - 8;  // 256 entries in all.

	logic                          clk;
	logic                          rst_n;
	logic [bp_pkg::IP_W-1:0]       ip;
	logic                          taken;
	logic                          hit;
	logic                          prediction;
	logic [bp_pkg::MISS_CNT_W-1:0] miss_count;
	logic                          exp_hit;
	logic                          exp_pred;
	logic [8*24-1:0]               test_name;
	int                            hit_errors;
	int                            pred_errors;
	int                            miss_errors;
	int                            cycle_count;

	// Shadow of the table, indexed by the low 8 address bits.
	logic [TAG_BITS-1:0]     sh_tag [256];
	logic [1:0]              sh_cnt [256];
	logic [bp_pkg::IP_W-1:0] sh_prev_ip;
	logic                    sh_valid;
	logic                    sh_arm;      // Low for the edge that ended reset.
	logic                    pend_taken;  // Outcome owed for the address now driven.

	branch_predictor #(.NUM_BANKS(4), .BANK_DEPTH(64)) i_dut (
		.clk(clk), .rst_n(rst_n), .ip(ip), .taken(taken),
		.hit(hit), .prediction(prediction), .miss_count(miss_count)
	);

	bp_checker i_checker (
		.clk(clk), .rst_n(rst_n), .test_name(test_name), .ip(ip), .taken(taken),
		.hit(hit), .prediction(prediction), .miss_count(miss_count),
		.exp_hit(exp_hit), .exp_pred(exp_pred), .hit_errors(hit_errors),
		.pred_errors(pred_errors), .miss_errors(miss_errors)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------
	// Reference model.
	// --------------------
	function automatic logic [1:0] predict(input logic [bp_pkg::IP_W-1:0] addr);
		logic h;
		h = (sh_tag[addr[7:0]] == addr[bp_pkg::IP_W-1:8]);
		return {h, h & sh_cnt[addr[7:0]][1]};  // Counter top bit, only on a hit.
	endfunction

	function automatic void shadow_update(input logic [bp_pkg::IP_W-1:0] addr,
			input logic outcome);
		logic [7:0] idx;
		idx = addr[7:0];
		if (sh_tag[idx] == addr[bp_pkg::IP_W-1:8]) begin
			if (outcome && sh_cnt[idx] != 2'd3) begin
				sh_cnt[idx] = sh_cnt[idx] + 2'd1;
			end else if (!outcome && sh_cnt[idx] != 2'd0) begin
				sh_cnt[idx] = sh_cnt[idx] - 2'd1;
			end
		end else begin
			sh_tag[idx] = addr[bp_pkg::IP_W-1:8];
			sh_cnt[idx] = outcome ? 2'd2 : 2'd1;  // Weak in the outcome's direction.
		end
	endfunction

	function automatic void reset_shadow();
		for (int k = 0; k < 256; k++) begin
			sh_tag[k] = '0;
			sh_cnt[k] = 2'd2;
		end
		sh_valid   = 1'b0;
		sh_arm     = 1'b0;
		pend_taken = 1'b0;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [TAG_BITS-1:0] pick_tag(input logic [1:0] sel);
		case (sel)
			2'd0:    return '0;
			2'd1:    return 56'h1;
			2'd2:    return 56'hab_cdef_0123_45;
			default: return '1;
		endcase
	endfunction

	// --------------------
	// Stimulus.
	// --------------------
	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		reset_shadow();
	endtask

	// Called on a falling edge; mirrors the rising edge just passed, then drives.
	task automatic step(input logic [bp_pkg::IP_W-1:0] addr, input logic outcome);
		if (sh_valid) begin
			shadow_update(sh_prev_ip, taken);
		end
		sh_prev_ip = ip;
		sh_valid   = sh_arm;
		sh_arm     = 1'b1;
		ip         = addr;
		taken      = pend_taken;
		pend_taken = outcome;
		{exp_hit, exp_pred} = predict(addr);
		@(negedge clk);
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the stimulus did not finish within %0d cycles.", TIMEOUT_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rng;
		int          total_errors;
		rst_n     = 1'b0;
		ip        = '0;
		taken     = 1'b0;
		exp_hit   = 1'b0;
		exp_pred  = 1'b0;
		test_name = "reset";
		reset_shadow();
		apply_reset();

		test_name = "reset_state";
		step(64'h0000_0000_0000_0014, 1'b1);
		step(64'h0000_0001_0000_0024, 1'b0);
		step(64'h0000_0000_0000_0000, 1'b1);
		step(64'h0000_dead_0000_0031, 1'b1);

		test_name = "saturation";  // Allocate, climb, hold, fall, hold.
		for (int i = 0; i < 11; i++) begin
			step(64'h5540, i < 4);
		end

		test_name = "allocation";  // Weak counters show after one opposite outcome.
		step(64'h6640, 1'b1);
		step(64'h6640, 1'b0);
		step(64'h6640, 1'b1);
		step(64'h6640, 1'b1);
		step(64'h7740, 1'b0);
		step(64'h7740, 1'b1);
		step(64'h7740, 1'b0);
		step(64'h7740, 1'b0);

		test_name = "bank_split";
		for (int i = 0; i < 12; i++) begin
			step({56'h88, 6'h20, i[1:0]}, i[0]);
		end

		test_name = "reset_again";
		apply_reset();

		test_name = "random_stream";
		rng = 32'h1872a368;
		for (int i = 0; i < RAND_LEN; i++) begin
			rng = xorshift(rng);
			step({pick_tag(rng[9:8]), 3'b000, rng[4:0]}, rng[20]);
		end

		test_name = "flush";  // Resolves the last outcome and its count.
		step('0, 1'b0);
		step('0, 1'b0);

		total_errors = hit_errors + pred_errors + miss_errors;
		$display("Errors: %0d hit, %0d prediction, %0d miss_count, %0d total",
			hit_errors, pred_errors, miss_errors, total_errors);
		if (total_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== branch_predictor.f ====
bp_pkg.sv
bp_addr_decode.sv
bp_bank.sv
bp_result_select.sv
branch_predictor.sv
bp_checker.sv
tb_branch_predictor.sv

// ==== Makefile ====
TOP := tb_branch_predictor

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f branch_predictor.f --Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log; then \
		echo "Simulation failed."; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
